//--- rtl/dpa_ctrl.sv
// photo album display controller, top level
// frame sequencer starts the copy and overlay address units,
// the combiner merges their requests onto the image port
`timescale 1ns/100ps

module dpa_ctrl #(
    parameter int FRAME_CYCLES = 1000000,
    parameter int PHOTO_WORDS  = 32
) (
    input  logic               clk,
    input  logic               reset,
    input  dpa_pkg::hms_time_t curr_time,
    input  dpa_pkg::im_addr_t  fb_addr,
    input  logic [1:0]         photo_num,
    input  dpa_pkg::im_addr_t  curr_photo_addr,
    output dpa_pkg::im_addr_t  im_a,
    output logic               im_wen_n,
    output logic [8:0]         cr_a,
    output logic               en_init_time,
    output logic               en_fb_addr,
    output logic               en_photo_num,
    output logic               en_curr_photo_addr,
    output logic               en_si,
    output logic               en_so,
    output logic               si_mux_sel,
    output logic [3:0]         expand_sel
);
    import dpa_pkg::*;

    seq_phase_e        phase;
    logic [ADDR_W-1:0] frame_cntr;
    logic [1:0]        curr_photo;
    agu_req_t          copy_req;
    agu_req_t          draw_req;
    logic              copy_done;
    logic              draw_done;

    frame_sequencer #(.FRAME_CYCLES(FRAME_CYCLES)) frame_sequencer_i (
        .clk(clk), .reset(reset), .copy_done(copy_done), .draw_done(draw_done),
        .photo_num(photo_num), .phase(phase), .frame_cntr(frame_cntr),
        .curr_photo(curr_photo), .en_init_time(en_init_time), .en_fb_addr(en_fb_addr),
        .en_photo_num(en_photo_num), .en_curr_photo_addr(en_curr_photo_addr)
    );

    photo_copy_agu #(.PHOTO_WORDS(PHOTO_WORDS)) photo_copy_agu_i (
        .clk(clk), .reset(reset), .phase(phase),
        .copy_req(copy_req), .copy_done(copy_done)
    );

    time_overlay_agu time_overlay_agu_i (
        .clk(clk), .reset(reset), .phase(phase), .curr_time(curr_time),
        .draw_req(draw_req), .draw_done(draw_done), .cr_a(cr_a), .expand_sel(expand_sel)
    );

    im_port_mux im_port_mux_i (
        .phase(phase), .frame_cntr(frame_cntr), .curr_photo(curr_photo),
        .fb_addr(fb_addr), .curr_photo_addr(curr_photo_addr),
        .copy_req(copy_req), .draw_req(draw_req),
        .im_a(im_a), .im_wen_n(im_wen_n), .en_si(en_si), .en_so(en_so),
        .si_mux_sel(si_mux_sel)
    );

endmodule

//--- rtl/dpa_pkg.sv
// digital photo album controller shared definitions
// address views, time fields, phase encoding, address unit requests
// and the glyph geometry of the clock overlay
package dpa_pkg;

    // --------------------
    // image memory addressing
    // --------------------
    localparam int ADDR_W = 20;

    typedef logic [ADDR_W-1:0] im_addr_t;

    // one frame buffer row is 256 words
    typedef struct packed {
        logic [11:0] row;
        logic [7:0]  col;
    } fb_rowcol_t;

    // linear for the photo copy, row/col for the overlay
    typedef union packed {
        im_addr_t   lin;
        fb_rowcol_t rc;
    } fb_word_u;

    // binary time fields, 8 bits each
    typedef struct packed {
        logic [7:0] hh;
        logic [7:0] mm;
        logic [7:0] ss;
    } hms_time_t;

    typedef enum logic [2:0] {
        SETUP,
        PHOTO_SET,
        PHOTO_COPY,
        TIME_DRAW,
        IDLE
    } seq_phase_e;

    // one address unit request to the image port combiner
    typedef struct packed {
        fb_word_u offset;    // base is added by the combiner
        logic     is_write;
        logic     si_strobe; // serial-in register load
        logic     so_active;
    } agu_req_t;

    // --------------------
    // overlay geometry and schedule
    // --------------------
    localparam int GLYPH_W     = 13;
    localparam int GLYPH_H     = 24;
    localparam int GLYPH_SLOTS = 8;
    localparam int COLON_GLYPH = 10;

    localparam im_addr_t CR_OFFSET = 20'hE898;

    localparam int SETUP_WORDS   = 5;  // header words at start-up
    localparam int PHOTO_SET_END = 6;
    localparam int COPY_SLOT     = 5;  // cycles per copied word pair

endpackage

//--- rtl/frame_sequencer.sv
// frame sequencer of the photo album controller
// keeps the frame counter and the phase register, decodes the header
// load strobes and steps the photo index at each frame wrap
`timescale 1ns/100ps

module frame_sequencer #(
    parameter int FRAME_CYCLES = 1000000
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       copy_done,
    input  logic                       draw_done,
    input  logic [1:0]                 photo_num,
    output dpa_pkg::seq_phase_e        phase,
    output logic [dpa_pkg::ADDR_W-1:0] frame_cntr,
    output logic [1:0]                 curr_photo,
    output logic                       en_init_time,
    output logic                       en_fb_addr,
    output logic                       en_photo_num,
    output logic                       en_curr_photo_addr
);
    import dpa_pkg::*;

    // header word positions within the frame
    localparam int TIME_WORD  = 2;
    localparam int FB_WORD    = 3;
    localparam int NUM_WORD   = 4;
    localparam int PHOTO_WORD = SETUP_WORDS;

    logic       frame_wrap;
    seq_phase_e phase_nxt;

    assign frame_wrap = (frame_cntr == ADDR_W'(FRAME_CYCLES - 1));

    // --------------------
    // frame counter
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            frame_cntr <= '0;
        end else if (frame_wrap) begin
            frame_cntr <= '0;
        end else begin
            frame_cntr <= frame_cntr + 1'b1;
        end
    end

    // --------------------
    // phase FSM
    // --------------------
    always_comb begin
        phase_nxt = phase;
        if (frame_wrap) begin
            phase_nxt = PHOTO_SET; // every later frame restarts here
        end else begin
            case (phase)
                SETUP:      if (frame_cntr == ADDR_W'(SETUP_WORDS - 1)) phase_nxt = PHOTO_SET;
                PHOTO_SET:  if (frame_cntr == ADDR_W'(PHOTO_SET_END)) phase_nxt = PHOTO_COPY;
                PHOTO_COPY: if (copy_done) phase_nxt = TIME_DRAW;
                TIME_DRAW:  if (draw_done) phase_nxt = IDLE;
                default:    phase_nxt = phase; // idle until wrap
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase <= SETUP;
        end else begin
            phase <= phase_nxt;
        end
    end

    // photo index steps once per frame
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            curr_photo <= 2'd0;
        end else if (frame_wrap) begin
            curr_photo <= (curr_photo == photo_num) ? 2'd0 : curr_photo + 2'd1;
        end
    end

    // the time strobe repeats in every frame
    assign en_init_time = (frame_cntr == ADDR_W'(TIME_WORD)) &&
                          (phase == SETUP || phase == PHOTO_SET);
    assign en_fb_addr   = (phase == SETUP) && (frame_cntr == ADDR_W'(FB_WORD));
    assign en_photo_num = (phase == SETUP) && (frame_cntr == ADDR_W'(NUM_WORD));
    assign en_curr_photo_addr = (phase == PHOTO_SET) && (frame_cntr == ADDR_W'(PHOTO_WORD));

endmodule

//--- rtl/im_port_mux.sv
// image port combiner
// selects the address source for the current phase and adds the
// photo or frame buffer base with no added latency
`timescale 1ns/100ps

module im_port_mux (
    input  dpa_pkg::seq_phase_e        phase,
    input  logic [dpa_pkg::ADDR_W-1:0] frame_cntr,
    input  logic [1:0]                 curr_photo,
    input  dpa_pkg::im_addr_t          fb_addr,
    input  dpa_pkg::im_addr_t          curr_photo_addr,
    input  dpa_pkg::agu_req_t          copy_req,
    input  dpa_pkg::agu_req_t          draw_req,
    output dpa_pkg::im_addr_t          im_a,
    output logic                       im_wen_n,
    output logic                       en_si,
    output logic                       en_so,
    output logic                       si_mux_sel
);
    import dpa_pkg::*;

    im_addr_t copy_base;

    // reads come from the photo, writes go to the frame buffer
    assign copy_base = copy_req.is_write ? fb_addr : curr_photo_addr;

    always_comb begin
        im_a       = '0;
        im_wen_n   = 1'b1;
        en_si      = 1'b0;
        en_so      = 1'b0;
        si_mux_sel = 1'b0;
        case (phase)
            SETUP: begin
                im_a = frame_cntr; // header words
            end
            PHOTO_SET: begin
                im_a = frame_cntr + im_addr_t'({curr_photo, 1'b0}); // two words per photo
            end
            PHOTO_COPY: begin
                im_a     = copy_base + copy_req.offset.lin;
                im_wen_n = ~copy_req.is_write;
                en_si    = copy_req.si_strobe;
                en_so    = copy_req.so_active;
            end
            TIME_DRAW: begin
                im_a       = fb_addr + CR_OFFSET + draw_req.offset.lin;
                im_wen_n   = ~draw_req.is_write;
                en_si      = draw_req.si_strobe;
                en_so      = draw_req.so_active;
                si_mux_sel = 1'b1; // serial-in takes rom data
            end
            default: begin
                im_a = '0;
            end
        endcase
    end

endmodule

//--- rtl/photo_copy_agu.sv
// photo copy address unit
// walks the current photo in five-cycle slots of two reads
// followed by two frame buffer writes
`timescale 1ns/100ps

module photo_copy_agu #(
    parameter int PHOTO_WORDS = 32
) (
    input  logic                clk,
    input  logic                reset,
    input  dpa_pkg::seq_phase_e phase,
    output dpa_pkg::agu_req_t   copy_req,
    output logic                copy_done
);
    import dpa_pkg::*;

    localparam int SLOTS      = PHOTO_WORDS / 2;
    localparam int SLOT_W     = (SLOTS > 1) ? $clog2(SLOTS) : 1;
    localparam int WRITE_STEP = 3; // steps 3 and 4 write

    logic [SLOT_W-1:0] slot_cnt;
    logic [2:0]        step_cnt;
    logic              active;
    logic              slot_last;
    logic              word_lsb;

    assign active    = (phase == PHOTO_COPY);
    assign slot_last = (step_cnt == 3'(COPY_SLOT - 1));
    assign copy_done = active && slot_last && (slot_cnt == SLOT_W'(SLOTS - 1));

    // --------------------
    // slot and step counters
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            slot_cnt <= '0;
            step_cnt <= 3'd0;
        end else if (!active || copy_done) begin
            slot_cnt <= '0;
            step_cnt <= 3'd0;
        end else if (slot_last) begin
            slot_cnt <= slot_cnt + 1'b1;
            step_cnt <= 3'd0;
        end else begin
            step_cnt <= step_cnt + 3'd1;
        end
    end

    // even word on the first read and the first write of a slot
    assign word_lsb = (step_cnt != 3'd0) && (step_cnt != 3'(WRITE_STEP));

    always_comb begin
        copy_req.offset.lin = im_addr_t'({slot_cnt, word_lsb});
        copy_req.is_write   = (step_cnt >= 3'(WRITE_STEP));
        // read data shows up one cycle after its address
        copy_req.si_strobe  = active && (step_cnt == 3'd1 || step_cnt == 3'd2);
        copy_req.so_active  = active;
    end

endmodule

//--- rtl/time_overlay_agu.sv
// clock overlay address unit
// splits the time into digits, reads one glyph row per segment
// from the character ROM and expands it into 13 pixel writes
`timescale 1ns/100ps

module time_overlay_agu (
    input  logic                clk,
    input  logic                reset,
    input  dpa_pkg::seq_phase_e phase,
    input  dpa_pkg::hms_time_t  curr_time,
    output dpa_pkg::agu_req_t   draw_req,
    output logic                draw_done,
    output logic [8:0]          cr_a,
    output logic [3:0]          expand_sel
);
    import dpa_pkg::*;

    localparam int SEG_LAST = GLYPH_W + 1; // rom read, latch, then 13 writes

    logic [2:0] slot_cnt;  // glyph position x
    logic [4:0] row_cnt;   // glyph row y
    logic [3:0] seg_cnt;   // cycle within segment
    logic       active;
    logic       seg_last;
    logic       row_last;
    logic       pix_cycle;
    logic [3:0] glyph;
    logic [3:0] hh_tens, hh_ones, mm_tens, mm_ones, ss_tens, ss_ones;

    assign active    = (phase == TIME_DRAW);
    assign seg_last  = (seg_cnt == 4'(SEG_LAST));
    assign row_last  = (row_cnt == 5'(GLYPH_H - 1));
    assign pix_cycle = (seg_cnt >= 4'd2);
    assign draw_done = active && seg_last && row_last && (slot_cnt == 3'(GLYPH_SLOTS - 1));

    // --------------------
    // slot / row / segment counters
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            slot_cnt <= 3'd0;
            row_cnt  <= 5'd0;
            seg_cnt  <= 4'd0;
        end else if (!active || draw_done) begin
            slot_cnt <= 3'd0;
            row_cnt  <= 5'd0;
            seg_cnt  <= 4'd0;
        end else if (seg_last) begin
            seg_cnt <= 4'd0;
            if (row_last) begin
                row_cnt  <= 5'd0;
                slot_cnt <= slot_cnt + 3'd1;
            end else begin
                row_cnt <= row_cnt + 5'd1;
            end
        end else begin
            seg_cnt <= seg_cnt + 4'd1;
        end
    end

    // decimal digits of the time
    assign hh_tens = 4'(curr_time.hh / 8'd10);
    assign hh_ones = 4'(curr_time.hh % 8'd10);
    assign mm_tens = 4'(curr_time.mm / 8'd10);
    assign mm_ones = 4'(curr_time.mm % 8'd10);
    assign ss_tens = 4'(curr_time.ss / 8'd10);
    assign ss_ones = 4'(curr_time.ss % 8'd10);

    always_comb begin
        case (slot_cnt)
            3'd0:    glyph = hh_tens;
            3'd1:    glyph = hh_ones;
            3'd3:    glyph = mm_tens;
            3'd4:    glyph = mm_ones;
            3'd6:    glyph = ss_tens;
            3'd7:    glyph = ss_ones;
            default: glyph = 4'(COLON_GLYPH); // slots 2 and 5
        endcase
    end

    // rom row of the current glyph while drawing
    assign cr_a       = active ? 9'(glyph * GLYPH_H + row_cnt) : 9'd0;
    assign expand_sel = (active && pix_cycle) ? seg_cnt - 4'd2 : 4'd0;

    always_comb begin
        draw_req.offset.rc.row = 12'(row_cnt);
        draw_req.offset.rc.col = 8'(slot_cnt * GLYPH_W) + {4'd0, expand_sel};
        draw_req.is_write      = pix_cycle;
        draw_req.si_strobe     = active && (seg_cnt == 4'd1); // latch rom row
        draw_req.so_active     = active;
    end

endmodule

//--- verification/dpa_ref_model.svh
// reference model of the photo album controller frame schedule
// steps frame counter, phase and photo index, and derives the
// expected image port, ROM and strobe values of each cycle
`ifndef DPA_REF_MODEL_SVH
`define DPA_REF_MODEL_SVH

localparam int       COPY_LEN     = 5 * PHOTO_WORDS / 2;
localparam int       SEG_LEN      = 15;         // rom read, latch, 13 pixels
localparam int       DRAW_LEN     = 8 * 24 * SEG_LEN;
localparam int       ROW_WORDS    = 256;
localparam im_addr_t OVERLAY_BASE = 20'hE898;

int         m_frame;
seq_phase_e m_phase;
logic [1:0] m_photo;
int         m_cnt;          // cycles since the phase began

im_addr_t   exp_im_a;
logic       exp_im_a_valid; // im_a is only defined on some cycles
logic       exp_wen_n;
logic [8:0] exp_cr_a;
logic [3:0] exp_sel;
logic       exp_init_time;
logic       exp_fb;
logic       exp_num;
logic       exp_photo_addr;
logic       exp_si;
logic       exp_so;
logic       exp_mux;

// glyph of overlay slot x in hh:mm:ss order
function automatic logic [3:0] glyph_of(input int x, input hms_time_t t);
    logic [7:0] field;
    field = (x < 3) ? t.hh : ((x < 6) ? t.mm : t.ss);
    if (x == 2 || x == 5) begin
        return 4'd10;
    end
    return (x % 3 == 0) ? 4'(field / 10) : 4'(field % 10);
endfunction

task automatic reset_model();
    m_frame = 0;
    m_phase = SETUP;
    m_photo = 2'd0;
    m_cnt   = 0;
endtask

task automatic step_model();
    if (m_frame == FRAME_CYCLES - 1) begin
        m_frame = 0;
        m_phase = PHOTO_SET;
        m_cnt   = 0;
        m_photo = (m_photo == photo_num) ? 2'd0 : m_photo + 2'd1;
    end else begin
        m_cnt = m_cnt + 1;
        case (m_phase)
            SETUP: begin
                if (m_frame == 4) m_phase = PHOTO_SET;
            end
            PHOTO_SET: begin
                if (m_frame == 6) begin
                    m_phase = PHOTO_COPY;
                    m_cnt   = 0;
                end
            end
            PHOTO_COPY: begin
                if (m_cnt == COPY_LEN) begin
                    m_phase = TIME_DRAW;
                    m_cnt   = 0;
                end
            end
            TIME_DRAW: begin
                if (m_cnt == DRAW_LEN) m_phase = IDLE;
            end
            default: ;
        endcase
        m_frame = m_frame + 1;
    end
endtask

task automatic predict_outputs();
    int       k;
    int       x;
    int       y;
    int       seg;
    im_addr_t base;
    exp_im_a       = '0;
    exp_im_a_valid = 1'b0;
    exp_wen_n      = 1'b1;
    exp_cr_a       = 9'd0;
    exp_sel        = 4'd0;
    exp_init_time  = 1'b0;
    exp_fb         = 1'b0;
    exp_num        = 1'b0;
    exp_photo_addr = 1'b0;
    exp_si         = 1'b0;
    exp_so         = 1'b0;
    exp_mux        = 1'b0;
    case (m_phase)
        SETUP, PHOTO_SET: begin
            // selection reads two header words per photo
            exp_im_a       = im_addr_t'(m_frame + ((m_phase == PHOTO_SET) ? 2 * m_photo : 0));
            exp_im_a_valid = 1'b1;
            exp_init_time  = (m_frame == 2);
            exp_fb         = (m_phase == SETUP) && (m_frame == 3);
            exp_num        = (m_phase == SETUP) && (m_frame == 4);
            exp_photo_addr = (m_phase == PHOTO_SET) && (m_frame == 5);
        end
        PHOTO_COPY: begin
            k              = m_cnt % 5;
            base           = (k < 3) ? curr_photo_addr : fb_addr;
            exp_im_a       = base + im_addr_t'(2 * (m_cnt / 5) + ((k == 0 || k == 3) ? 0 : 1));
            exp_im_a_valid = 1'b1;
            exp_wen_n      = (k < 3);
            exp_si         = (k == 1 || k == 2);
            exp_so         = 1'b1;
        end
        TIME_DRAW: begin
            seg            = m_cnt % SEG_LEN;
            y              = (m_cnt / SEG_LEN) % 24;
            x              = m_cnt / (SEG_LEN * 24);
            exp_cr_a       = 9'(glyph_of(x, curr_time) * 24 + y);
            exp_sel        = (seg >= 2) ? 4'(seg - 2) : 4'd0;
            exp_im_a       = fb_addr + OVERLAY_BASE + im_addr_t'(y * ROW_WORDS + x * 13 + seg - 2);
            exp_im_a_valid = (seg >= 2);
            exp_wen_n      = (seg < 2);
            exp_si         = (seg == 1);
            exp_so         = 1'b1;
            exp_mux        = 1'b1;
        end
        default: ;
    endcase
endtask

`endif

//--- verification/tb_dpa_ctrl.sv
// testbench for the photo album display controller
// draws random header values and times once per frame and compares
// every output each cycle against the frame schedule model
`timescale 1ns/100ps

module tb_dpa_ctrl;
    import dpa_pkg::*;

    localparam int FRAME_CYCLES = 3200;
    localparam int PHOTO_WORDS  = 32;
    localparam int RUN_FRAMES   = 4;
    localparam int CYCLE_LIMIT  = RUN_FRAMES * FRAME_CYCLES + 200;

    logic       clk;
    logic       reset;
    hms_time_t  curr_time;
    im_addr_t   fb_addr;
    logic [1:0] photo_num;
    im_addr_t   curr_photo_addr;
    im_addr_t   im_a;
    logic       im_wen_n;
    logic [8:0] cr_a;
    logic       en_init_time;
    logic       en_fb_addr;
    logic       en_photo_num;
    logic       en_curr_photo_addr;
    logic       en_si;
    logic       en_so;
    logic       si_mux_sel;
    logic [3:0] expand_sel;

    int   seed;
    int   cycle_cnt = 0;
    logic inputs_drawn = 1'b0;

    `include "dpa_ref_model.svh"

    dpa_ctrl #(.FRAME_CYCLES(FRAME_CYCLES), .PHOTO_WORDS(PHOTO_WORDS)) dpa_ctrl_i (
        .clk(clk), .reset(reset), .curr_time(curr_time), .fb_addr(fb_addr),
        .photo_num(photo_num), .curr_photo_addr(curr_photo_addr),
        .im_a(im_a), .im_wen_n(im_wen_n), .cr_a(cr_a),
        .en_init_time(en_init_time), .en_fb_addr(en_fb_addr), .en_photo_num(en_photo_num),
        .en_curr_photo_addr(en_curr_photo_addr), .en_si(en_si), .en_so(en_so),
        .si_mux_sel(si_mux_sel), .expand_sel(expand_sel)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic stop_run();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    // --------------------
    // compare tasks
    // --------------------
    task automatic check_addr(input string name, input im_addr_t exp, input im_addr_t act);
        if (act !== exp) begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_cr(input string name, input logic [8:0] exp, input logic [8:0] act);
        if (act !== exp) begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_sel(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp) begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic compare_outputs();
        predict_outputs();
        if (exp_im_a_valid) check_addr("im_a", exp_im_a, im_a);
        check_bit("im_wen_n", exp_wen_n, im_wen_n);
        check_cr("cr_a", exp_cr_a, cr_a);
        check_sel("expand_sel", exp_sel, expand_sel);
        check_bit("en_init_time", exp_init_time, en_init_time);
        check_bit("en_fb_addr", exp_fb, en_fb_addr);
        check_bit("en_photo_num", exp_num, en_photo_num);
        check_bit("en_curr_photo_addr", exp_photo_addr, en_curr_photo_addr);
        check_bit("en_si", exp_si, en_si);
        check_bit("en_so", exp_so, en_so);
        check_bit("si_mux_sel", exp_mux, si_mux_sel);
    endtask

    // bases kept below 2^19 so base plus offset fits 20 bits
    task automatic draw_inputs();
        hms_time_t t;
        t.hh = 8'($unsigned($random(seed)) % 24);
        t.mm = 8'($unsigned($random(seed)) % 60);
        t.ss = 8'($unsigned($random(seed)) % 60);
        curr_time       <= t;
        fb_addr         <= im_addr_t'($random(seed)) & 20'h7FFFF;
        curr_photo_addr <= im_addr_t'($random(seed)) & 20'h7FFFF;
        photo_num       <= 2'($random(seed));
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout, the run did not end within %0d cycles", CYCLE_LIMIT);
            stop_run();
        end
    end

    // --------------------
    // main sequence
    // --------------------
    initial begin
        seed = 84949;
        reset <= 1'b1;
        draw_inputs();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        reset_model();
        for (int i = 0; i < RUN_FRAMES * FRAME_CYCLES; i++) begin
            @(negedge clk);
            compare_outputs();
            @(posedge clk);
            step_model();
            if (m_frame == 0) inputs_drawn = 1'b0;
            // new values only while the DUT is idle
            if (m_phase == IDLE && !inputs_drawn) begin
                draw_inputs();
                inputs_drawn = 1'b1;
            end
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+verification
rtl/dpa_pkg.sv
rtl/frame_sequencer.sv
rtl/photo_copy_agu.sv
rtl/time_overlay_agu.sv
rtl/im_port_mux.sv
rtl/dpa_ctrl.sv
verification/tb_dpa_ctrl.sv
